// File: sdramController.f
hdl/sdramPkg.sv
hdl/burstIf.sv
hdl/portFifo.sv
hdl/burstScheduler.sv
hdl/sdramSequencer.sv
hdl/sdramController.sv
testbench/sdramModel.sv
testbench/tbSdramController.sv

// File: testbench/tbSdramController.sv
`timescale 1ns/10ps
`default_nettype none

module tbSdramController;
	import sdramPkg::*;

	localparam int BURST_CYCLES = 1 + T_RCD + 8 + 1 + 1 + T_RP + 2;
	localparam int NUM_BURSTS   = (64 + 48) / 8 + (64 + 32 + 40 + 20 + 8 + 32) / 8;
	localparam int WATCH_CYCLES = 20 * NUM_BURSTS * BURST_CYCLES + INIT_WAIT + 16;

	logic CLK, RESET_N, wrReq, rdReq, wrLoad, rdLoad;
	dataT wrData;
	wordAddrT wrStart, wrMax, rdStart, rdMax;
	burstLenT wrLen, rdLen;
	wire wrFull, rdEmpty, initDone, csN, cke, rasN, casN, weN;
	wire fillT wrUse;
	wire dataT rdData;
	wire dataT dq;
	wire [ROW_W-1:0] sa;
	wire [BANK_W-1:0] ba;
	wire [1:0] dqm;
	int errors = 0;
	int protoErrors;
	logic modeSeen = 1'b0;

	dataT refMem [wordAddrT];                               // Expected memory contents
	wordAddrT wrBase, wrStartT, wrMaxT, rdBase, rdStartT, rdMaxT;
	burstLenT wrLenT, rdLenT;
	int wrOff, rdOff;

	sdramController UUT (
		.CLK, .RESET_N, .wrData, .wrReq, .wrFull, .wrUse, .rdData, .rdReq, .rdEmpty,
		.wrLoad, .rdLoad, .wrStart, .wrMax, .rdStart, .rdMax, .wrLen, .rdLen,
		.initDone, .sa, .ba, .csN, .cke, .rasN, .casN, .weN, .dq, .dqm
	);

	sdramModel memory (
		.CLK, .sa, .ba, .csN, .rasN, .casN, .weN, .dq, .errors(protoErrors)
	);

	// Next burst base: back to start once base reaches max minus len
	function automatic wordAddrT nextBurstBase(wordAddrT base, wordAddrT start,
		wordAddrT maxA, burstLenT len);
		if (base >= maxA - wordAddrT'(len))
			return start;
		return base + wordAddrT'(len);
	endfunction

	function automatic dataT expectedWord(wordAddrT addr);
		if (refMem.exists(addr))
			return refMem[addr];
		return '0;
	endfunction

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Power-up commands and mode word
	always @(posedge CLK)
	begin
		if (RESET_N && !initDone && !csN)
		begin
			assert ({rasN, casN, weN} inside {CMD_NOP, CMD_PRE, CMD_REF, CMD_MRS})
				else begin
					$display("Unexpected command before initialization finished");
					errors++;
				end
			if ({rasN, casN, weN} == CMD_PRE)
				assert (sa[10]) else begin
					$display("Power-up precharge does not cover all banks");
					errors++;
				end
			if ({rasN, casN, weN} == CMD_MRS)
			begin
				modeSeen = 1'b1;
				assert (sa == MODE_WORD) else begin
					$display("Fail sa %h expected %h", sa, MODE_WORD);
					errors++;
				end
			end
		end
	end

	// Single chip, clock always enabled, no masking
	always @(posedge CLK)
	begin
		if (RESET_N)
			assert (csN == 1'b0 && cke == 1'b1 && dqm == 2'b00) else begin
				$display("Fail csN %h cke %h dqm %h expected 0 1 0", csN, cke, dqm);
				errors++;
			end
	end

	// Compare each popped word with the reference
	always @(posedge CLK)
	begin
		dataT exp;
		if (RESET_N && rdReq && !rdEmpty)
		begin
			exp = expectedWord(rdBase + wordAddrT'(rdOff));
			assert (rdData == exp) else begin
				$display("Fail rdData %h expected %h", rdData, exp);
				errors++;
			end
			rdOff++;
			if (rdOff == int'(rdLenT))
			begin
				rdBase = nextBurstBase(rdBase, rdStartT, rdMaxT, rdLenT);
				rdOff  = 0;
			end
		end
	end

	task automatic loadWrite(wordAddrT start, wordAddrT maxA, burstLenT len);
		@(negedge CLK);
		{wrStart, wrMax, wrLen} = {start, maxA, len};
		wrLoad = 1'b1;
		{wrBase, wrStartT, wrMaxT, wrLenT, wrOff} = {start, start, maxA, len, 32'd0};
		@(negedge CLK);
		wrLoad = 1'b0;
	endtask

	// Disable first so that no old burst lands in the cleared FIFO
	task automatic loadRead(wordAddrT start, wordAddrT maxA, burstLenT len);
		@(negedge CLK);
		{rdStart, rdMax, rdLen} = {start, maxA, 5'd0};
		rdLoad = 1'b1;
		@(negedge CLK);
		rdLoad = 1'b0;
		while (UUT.burstBus.req)
			@(negedge CLK);
		rdLen  = len;
		rdLoad = 1'b1;
		{rdBase, rdStartT, rdMaxT, rdLenT, rdOff} = {start, start, maxA, len, 32'd0};
		@(negedge CLK);
		rdLoad = 1'b0;
	endtask

	task automatic pushWords(int n, bit waitRoom);
		repeat (n)
		begin
			@(negedge CLK);
			wrReq = 1'b0;
			while (waitRoom && wrFull)
				@(negedge CLK);
			wrData = dataT'($urandom);
			wrReq  = 1'b1;
			if (!wrFull && wrLenT != '0)
			begin
				refMem[wrBase + wordAddrT'(wrOff)] = wrData;
				wrOff++;
				if (wrOff == int'(wrLenT))
				begin
					wrBase = nextBurstBase(wrBase, wrStartT, wrMaxT, wrLenT);
					wrOff  = 0;
				end
			end
		end
		@(negedge CLK);
		wrReq = 1'b0;
	endtask

	task automatic popWords(int n);
		repeat (n)
		begin
			@(negedge CLK);
			rdReq = 1'b0;
			while (rdEmpty)
				@(negedge CLK);
			rdReq = 1'b1;
		end
		@(negedge CLK);
		rdReq = 1'b0;
	endtask

	task automatic waitWritesDone();
		@(negedge CLK);
		while (wrUse != '0 || UUT.burstBus.req)
			@(negedge CLK);
	endtask

	initial
	begin
		repeat (WATCH_CYCLES) @(posedge CLK);
		$display("Timeout after %0d cycles, bursts did not complete", WATCH_CYCLES);
		$display("Errors: checks %0d, protocol %0d", errors, protoErrors);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h5449_72a7));
		{RESET_N, wrReq, rdReq, wrLoad, rdLoad, wrData} = '0;
		{wrStart, wrMax, rdStart, rdMax, wrLen, rdLen} = '0;
		{wrBase, wrStartT, wrMaxT, rdBase, rdStartT, rdMaxT} = '0;
		{wrLenT, rdLenT, wrOff, rdOff} = '0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		RESET_N = 1'b1;
		@(negedge CLK);
		assert (rdEmpty == 1'b1 && wrFull == 1'b0) else begin
			$display("Fail rdEmpty %h wrFull %h after reset", rdEmpty, wrFull);
			errors++;
		end
		while (!initDone)
			@(negedge CLK);
		assert (modeSeen) else begin
			$display("No mode register command before initDone");
			errors++;
		end
		loadWrite(22'd0, 22'd64, 5'd8);                     // 64-word write window
		pushWords(64, 1'b1);
		waitWritesDone();
		loadRead(22'd0, 22'd64, 5'd8);
		popWords(64);
		while (!(UUT.rdLevel == fillT'(FIFO_DEPTH) && !UUT.burstBus.req))
			@(negedge CLK);
		repeat (BURST_CYCLES) @(negedge CLK);
		assert (rdEmpty == 1'b0) else begin
			$display("Fail rdEmpty %h under back-pressure", rdEmpty);
			errors++;
		end
		assert (!UUT.burstBus.req && UUT.rdLevel == fillT'(FIFO_DEPTH)) else begin
			$display("Read burst requested while the read FIFO had no room");
			errors++;
		end
		popWords(40);                                       // Carries on past the wrap
		loadWrite(22'd256, 22'd272, 5'd8);                  // 16-word window, written three times
		pushWords(48, 1'b1);
		waitWritesDone();
		loadRead(22'd256, 22'd272, 5'd8);
		popWords(20);                                       // Window plus half a burst
		loadRead(22'd256, 22'd272, 5'd8);                   // Restart, first words repeat
		popWords(8);
		loadWrite(22'd512, 22'd576, 5'd0);                  // Port disabled, FIFO only fills
		pushWords(FIFO_DEPTH + 2, 1'b0);
		@(negedge CLK);
		assert (wrFull == 1'b1 && wrUse == fillT'(FIFO_DEPTH)) else begin
			$display("Fail wrFull %h wrUse %h when overfilled", wrFull, wrUse);
			errors++;
		end
		loadWrite(22'd512, 22'd576, 5'd0);
		@(negedge CLK);
		assert (wrFull == 1'b0) else begin
			$display("Fail wrFull %h after load", wrFull);
			errors++;
		end
		repeat (4) @(negedge CLK);
		$display("Errors: checks %0d, protocol %0d", errors, protoErrors);
		if (errors == 0 && protoErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/sdramModel.sv
`timescale 1ns/10ps
`default_nettype none

module sdramModel
	import sdramPkg::*;
(
	input  wire               CLK,
	input  wire [ROW_W-1:0]   sa,
	input  wire [BANK_W-1:0]  ba,
	input  wire               csN,
	input  wire               rasN,
	input  wire               casN,
	input  wire               weN,
	inout  wire dataT         dq,
	output int                errors
);

	dataT mem [wordAddrT];                                  // Keyed by {bank, row, column}
	logic [ROW_W-1:0] openRow [2**BANK_W];
	logic [2**BANK_W-1:0] bankOpen = '0;
	int sinceAct = 100;
	int sincePre = 100;
	logic writing = 1'b0;
	logic reading = 1'b0;
	logic [BANK_W-1:0] curBank;
	logic [COL_W-1:0] col;
	logic p1Valid = 1'b0;
	dataT p1Data;
	logic drvEn = 1'b0;
	dataT drvData;

	initial errors = 0;

	assign dq = drvEn ? drvData : 'z;                       // Read data CAS_LAT after column

	always @(posedge CLK)
	begin
		logic [2:0] cmd;
		logic beat;
		wordAddrT key;
		cmd  = csN ? CMD_NOP : {rasN, casN, weN};
		beat = 1'b0;
		sinceAct = (sinceAct < 100) ? sinceAct + 1 : sinceAct;
		sincePre = (sincePre < 100) ? sincePre + 1 : sincePre;
		if (cmd != CMD_NOP && sinceAct < T_RCD)
		begin
			$display("Command issued during tRCD at %0t", $time);
			errors++;
		end
		if (cmd != CMD_NOP && sincePre < T_RP)
		begin
			$display("Command issued during tRP at %0t", $time);
			errors++;
		end
		case (cmd)
			CMD_ACT:
			begin
				if (bankOpen[ba])
				begin
					$display("Activate to an already open bank at %0t", $time);
					errors++;
				end
				bankOpen[ba] = 1'b1;
				openRow[ba]  = sa;
				sinceAct     = 0;
			end
			CMD_READ, CMD_WRITE:
			begin
				if (!bankOpen[ba])
				begin
					$display("Read or write to a closed row at %0t", $time);
					errors++;
				end
				curBank = ba;
				col     = sa[COL_W-1:0];
				writing = (cmd == CMD_WRITE);
				reading = (cmd == CMD_READ);
			end
			CMD_BST:
			begin
				writing = 1'b0;
				reading = 1'b0;
			end
			CMD_PRE:
			begin
				if (sa[10])
					bankOpen = '0;                          // Precharge all
				else
					bankOpen[ba] = 1'b0;
				writing  = 1'b0;
				reading  = 1'b0;
				sincePre = 0;
			end
			default: ;
		endcase
		key = {curBank, openRow[curBank], col};
		if (writing && (cmd == CMD_WRITE || cmd == CMD_NOP))
		begin
			mem[key] = dq;
			col++;
		end
		if (reading && (cmd == CMD_READ || cmd == CMD_NOP))
		begin
			beat = 1'b1;
			p1Data <= mem.exists(key) ? mem[key] : '0;
			col++;
		end
		p1Valid <= beat;
		drvEn   <= p1Valid;
		drvData <= p1Data;
	end

endmodule

`default_nettype wire

// File: hdl/sdramController.sv
`timescale 1ns/10ps
`default_nettype none

module sdramController
	import sdramPkg::*;
(
	input  wire                 CLK,
	input  wire                 RESET_N,
	input  wire dataT           wrData,
	input  wire                 wrReq,
	output logic                wrFull,
	output fillT                wrUse,
	output dataT                rdData,
	input  wire                 rdReq,
	output logic                rdEmpty,
	input  wire                 wrLoad,
	input  wire                 rdLoad,
	input  wire wordAddrT       wrStart,
	input  wire wordAddrT       wrMax,
	input  wire wordAddrT       rdStart,
	input  wire wordAddrT       rdMax,
	input  wire burstLenT       wrLen,
	input  wire burstLenT       rdLen,
	output logic                initDone,
	output logic [ROW_W-1:0]    sa,
	output logic [BANK_W-1:0]   ba,
	output logic                csN,
	output logic                cke,
	output logic                rasN,
	output logic                casN,
	output logic                weN,
	inout  wire dataT           dq,
	output logic [DATA_W/8-1:0] dqm
);

	dataT fifoWrData;                                       // Write FIFO head
	dataT seqRdData;                                        // Captured DQ word
	logic wrPop;
	logic rdPush;
	fillT rdLevel;

	burstIf burstBus ();

	portFifo writeFifo (
		.CLK, .RESET_N,
		.clear(wrLoad),
		.push(wrReq), .pushData(wrData),
		.pop(wrPop), .popData(fifoWrData),
		.level(wrUse), .full(wrFull), .empty()
	);

	portFifo readFifo (
		.CLK, .RESET_N,
		.clear(rdLoad),
		.push(rdPush), .pushData(seqRdData),
		.pop(rdReq), .popData(rdData),
		.level(rdLevel), .full(), .empty(rdEmpty)
	);

	burstScheduler scheduler (
		.CLK, .RESET_N, .initDone,
		.wrLoad, .rdLoad,
		.wrStart, .wrMax, .rdStart, .rdMax,
		.wrLen, .rdLen,
		.wrLevel(wrUse), .rdLevel,
		.burst(burstBus)
	);

	sdramSequencer sequencer (
		.CLK, .RESET_N,
		.burst(burstBus),
		.wrPop, .wrData(fifoWrData),
		.rdPush, .rdData(seqRdData),
		.initDone,
		.sa, .ba, .csN, .cke, .rasN, .casN, .weN, .dqm,
		.dq
	);

endmodule

`default_nettype wire

// File: hdl/sdramSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sdramSequencer
	import sdramPkg::*;
(
	input  wire                 CLK,
	input  wire                 RESET_N,
	burstIf.consumer            burst,
	output logic                wrPop,
	input  wire dataT           wrData,
	output logic                rdPush,
	output dataT                rdData,
	output logic                initDone,
	output logic [ROW_W-1:0]    sa,
	output logic [BANK_W-1:0]   ba,
	output logic                csN,
	output logic                cke,
	output logic                rasN,
	output logic                casN,
	output logic                weN,
	output logic [DATA_W/8-1:0] dqm,
	inout  wire dataT           dq
);

	seqStateT state;
	logic [7:0] cnt;                                        // Cycles within a step
	logic [2:0] cmd;
	logic refDone;
	logic dqOe;
	logic readBeat;                                         // Column read in this cycle
	logic [CAS_LAT:0] rdPipe;
	logic rowOpen;
	logic actCmd;
	logic preCmd;
	logic [BANK_W-1:0] reqBank;
	logic [ROW_W-1:0] reqRow;
	logic [COL_W-1:0] reqCol;

	assign reqBank = burst.addr[ADDR_W-1 -: BANK_W];
	assign reqRow  = burst.addr[COL_W +: ROW_W];
	assign reqCol  = burst.addr[COL_W-1:0];

	assign {rasN, casN, weN} = cmd;
	assign csN    = 1'b0;                                   // Single chip
	assign cke    = 1'b1;
	assign dqm    = '0;
	assign dq     = dqOe ? wrData : 'z;                     // FIFO head straight to the pins
	assign actCmd = (cmd == CMD_ACT);
	assign preCmd = (cmd == CMD_PRE);

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state      <= INIT_WAIT_ST;
			cnt        <= '0;
			cmd        <= CMD_NOP;
			sa         <= '0;
			ba         <= '0;
			refDone    <= 1'b0;
			initDone   <= 1'b0;
			dqOe       <= 1'b0;
			wrPop      <= 1'b0;
			readBeat   <= 1'b0;
			burst.done <= 1'b0;
		end
		else
		begin
			cmd        <= CMD_NOP;
			burst.done <= 1'b0;
			cnt        <= cnt + 8'd1;
			case (state)
				INIT_WAIT_ST:
					if (cnt == 8'(INIT_WAIT - 1))
					begin
						cmd    <= CMD_PRE;
						sa[10] <= 1'b1;                     // All banks
						cnt    <= '0;
						state  <= INIT_PRE;
					end
				INIT_PRE:
					if (cnt == 8'(T_RP - 1))
					begin
						cmd   <= CMD_REF;
						cnt   <= '0;
						state <= INIT_REF;
					end
				INIT_REF:
					if (cnt == 8'(T_RFC - 1))
					begin
						cnt <= '0;
						if (refDone)
						begin
							cmd   <= CMD_MRS;
							sa    <= MODE_WORD;
							ba    <= '0;
							state <= INIT_MODE;
						end
						else
						begin
							cmd     <= CMD_REF;             // Second refresh
							refDone <= 1'b1;
						end
					end
				INIT_MODE:
					if (cnt == 8'd1)                        // tMRD of two cycles
					begin
						initDone <= 1'b1;
						state    <= IDLE;
					end
				IDLE:
					if (burst.req && !burst.done)
					begin
						cmd   <= CMD_ACT;
						sa    <= reqRow;
						ba    <= reqBank;
						state <= ACTIVATE;
					end
				ACTIVATE:
				begin
					cnt   <= 8'd1;
					state <= RCD_WAIT;
				end
				RCD_WAIT:
					if (cnt == 8'(T_RCD - 1))
					begin
						cnt <= 8'd1;
						sa  <= ROW_W'(reqCol);              // A10 low, no auto precharge
						if (burst.isWrite)
						begin
							cmd   <= CMD_WRITE;
							dqOe  <= 1'b1;
							wrPop <= 1'b1;
							state <= WRITE_BURST;
						end
						else
						begin
							cmd      <= CMD_READ;
							readBeat <= 1'b1;
							state    <= READ_BURST;
						end
					end
				WRITE_BURST, READ_BURST:
					if (cnt == 8'(burst.len))               // Last column this cycle
					begin
						cmd      <= CMD_BST;
						dqOe     <= 1'b0;
						wrPop    <= 1'b0;
						readBeat <= 1'b0;
						state    <= TERMINATE;
					end
				TERMINATE:
				begin
					cmd    <= CMD_PRE;                      // Bank still on ba
					sa[10] <= 1'b0;
					state  <= PRECHARGE;
				end
				PRECHARGE:
				begin
					cnt   <= 8'd1;
					state <= RP_WAIT;
				end
				RP_WAIT:
					if (cnt == 8'(T_RP - 1))
					begin
						burst.done <= 1'b1;
						state      <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Word on DQ CAS_LAT cycles after its column, pushed one cycle after capture
	always_ff @(posedge CLK)
	begin
		rdData <= dq;
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			rdPipe <= '0;
		else
			rdPipe <= {rdPipe[CAS_LAT-1:0], readBeat};
	end

	assign rdPush = rdPipe[CAS_LAT];

	// Open-row tracking from the command pins
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			rowOpen <= 1'b0;
		else if (actCmd)
			rowOpen <= 1'b1;
		else if (preCmd)
			rowOpen <= 1'b0;
	end

	assert property (@(posedge CLK) disable iff (!RESET_N) actCmd |-> !rowOpen)
		else $error("Activate issued while a row is open");

endmodule

`default_nettype wire

// File: hdl/burstScheduler.sv
`timescale 1ns/10ps
`default_nettype none

module burstScheduler
	import sdramPkg::*;
(
	input  wire           CLK,
	input  wire           RESET_N,
	input  wire           initDone,
	input  wire           wrLoad,
	input  wire           rdLoad,
	input  wire wordAddrT wrStart,
	input  wire wordAddrT wrMax,
	input  wire wordAddrT rdStart,
	input  wire wordAddrT rdMax,
	input  wire burstLenT wrLen,
	input  wire burstLenT rdLen,
	input  wire fillT     wrLevel,
	input  wire fillT     rdLevel,
	burstIf.producer      burst
);

	wordAddrT wrAddr, wrStartR, wrMaxR;
	wordAddrT rdAddr, rdStartR, rdMaxR;
	burstLenT wrLenR, rdLenR;
	logic canStart;
	logic startRd;
	logic startWr;

	// Step by len, back to start once the last slot of the window is used
	function automatic wordAddrT nextAddr(wordAddrT cur, wordAddrT start, wordAddrT maxA,
		burstLenT len);
		wordAddrT step;
		step = wordAddrT'(len);
		if (cur >= maxA - step)
			return start;
		return cur + step;
	endfunction

	assign canStart = initDone && !burst.req && !wrLoad && !rdLoad;
	assign startRd  = canStart && (rdLenR != '0)
		&& ((fillT'(FIFO_DEPTH) - rdLevel) >= fillT'(rdLenR));   // Room for a whole burst
	assign startWr  = canStart && !startRd && (wrLenR != '0) && (wrLevel >= fillT'(wrLenR));

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrAddr   <= '0;
			wrStartR <= '0;
			wrMaxR   <= '0;
			wrLenR   <= '0;                                 // Port disabled
			rdAddr   <= '0;
			rdStartR <= '0;
			rdMaxR   <= '0;
			rdLenR   <= '0;
		end
		else
		begin
			if (wrLoad)
			begin
				wrAddr   <= wrStart;
				wrStartR <= wrStart;
				wrMaxR   <= wrMax;
				wrLenR   <= wrLen;
			end
			else if (burst.done && burst.isWrite)
				wrAddr <= nextAddr(wrAddr, wrStartR, wrMaxR, wrLenR);
			if (rdLoad)
			begin
				rdAddr   <= rdStart;
				rdStartR <= rdStart;
				rdMaxR   <= rdMax;
				rdLenR   <= rdLen;
			end
			else if (burst.done && !burst.isWrite)
				rdAddr <= nextAddr(rdAddr, rdStartR, rdMaxR, rdLenR);
		end
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			burst.req <= 1'b0;
		else if (burst.done)
			burst.req <= 1'b0;
		else if (startRd || startWr)
			burst.req <= 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (startRd || startWr)
		begin
			burst.isWrite <= startWr;
			burst.addr    <= startWr ? wrAddr : rdAddr;
			burst.len     <= startWr ? wrLenR : rdLenR;
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET_N)
		burst.req && !burst.done |=> burst.req && $stable(burst.isWrite)
			&& $stable(burst.addr) && $stable(burst.len))
		else $error("Burst request dropped or changed before done");

endmodule

`default_nettype wire

// File: hdl/portFifo.sv
`timescale 1ns/10ps
`default_nettype none

module portFifo
	import sdramPkg::*;
(
	input  wire       CLK,
	input  wire       RESET_N,
	input  wire       clear,
	input  wire       push,
	input  wire dataT pushData,
	input  wire       pop,
	output dataT      popData,
	output fillT      level,
	output logic      full,
	output logic      empty
);

	dataT mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wrPtr;
	logic [$clog2(FIFO_DEPTH)-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign doPush  = push && !full;                         // Overflow dropped
	assign doPop   = pop && !empty;
	assign full    = (level == fillT'(FIFO_DEPTH));
	assign empty   = (level == '0);
	assign popData = mem[rdPtr];                            // Head word, show-ahead

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (doPush && !doPop)
				level <= level + 1'b1;
			else if (doPop && !doPush)
				level <= level - 1'b1;
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET_N) !(push && full))
		else $warning("FIFO push while full, word dropped");
	assert property (@(posedge CLK) disable iff (!RESET_N) !(pop && empty))
		else $error("FIFO pop while empty");

endmodule

`default_nettype wire

// File: hdl/burstIf.sv
`timescale 1ns/10ps
`default_nettype none

interface burstIf
	import sdramPkg::*;
();

	logic     req;                                          // Held until done
	logic     isWrite;
	wordAddrT addr;                                         // First word of the burst
	burstLenT len;
	logic     done;                                         // One cycle after tRP

	modport producer (
		output req, output isWrite, output addr, output len,
		input  done
	);

	modport consumer (
		input  req, input isWrite, input addr, input len,
		output done
	);

endinterface

`default_nettype wire

// File: hdl/sdramPkg.sv
`default_nettype none

package sdramPkg;

	localparam int DATA_W     = 16;
	localparam int BANK_W     = 2;
	localparam int ROW_W      = 12;
	localparam int COL_W      = 8;
	localparam int ADDR_W     = BANK_W + ROW_W + COL_W;     // {bank, row, column}
	localparam int FIFO_DEPTH = 32;

	localparam int CAS_LAT    = 2;
	localparam int T_RCD      = 2;
	localparam int T_RP       = 2;
	localparam int T_RFC      = 7;
	localparam int INIT_WAIT  = 200;                        // Short power-up wait

	// Full page, sequential, CAS latency from CAS_LAT, burst writes
	localparam logic [11:0] MODE_WORD = {5'b00000, 3'(CAS_LAT), 1'b0, 3'b111};

	// {rasN, casN, weN}
	localparam logic [2:0] CMD_MRS   = 3'b000;
	localparam logic [2:0] CMD_REF   = 3'b001;
	localparam logic [2:0] CMD_PRE   = 3'b010;
	localparam logic [2:0] CMD_ACT   = 3'b011;
	localparam logic [2:0] CMD_WRITE = 3'b100;
	localparam logic [2:0] CMD_READ  = 3'b101;
	localparam logic [2:0] CMD_BST   = 3'b110;
	localparam logic [2:0] CMD_NOP   = 3'b111;

	typedef logic [DATA_W-1:0] dataT;
	typedef logic [ADDR_W-1:0] wordAddrT;
	typedef logic [4:0]        burstLenT;                   // 1 to 16 words
	typedef logic [5:0]        fillT;                       // 0 to FIFO_DEPTH

	typedef enum logic [3:0] {
		INIT_WAIT_ST, INIT_PRE, INIT_REF, INIT_MODE,
		IDLE, ACTIVATE, RCD_WAIT, WRITE_BURST, READ_BURST,
		TERMINATE, PRECHARGE, RP_WAIT
	} seqStateT;

endpackage

`default_nettype wire
